/* vlog.f */
logic/mipsPkg.sv
logic/ctrlBus.sv
logic/control.sv
logic/alu.sv
logic/regFile.sv
logic/mipsCore.sv
tb/mipsCore_assert.sv
tb/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsCoreTb -f vlog.f -o mipsCoreSim

out=$(./obj_dir/mipsCoreSim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

/* tb/mipsCoreTb.sv */
`timescale 1ns/100ps

module mipsCoreTb;
	import mipsPkg::*;

	localparam logic [31:0] tbResetPc = 32'h0040_0000;
	localparam int memWords = 256;
	localparam int resetCycles = 4;
	localparam int numTests = 6;
	localparam int cycleBudget = 100;
	localparam int timeoutLimit = numTests * (cycleBudget + resetCycles + 2) + 50;

	// branch cases, kind 0..5 is beq bne bgtz blez bltz bgez
	localparam int brKind [15] = '{0, 0, 1, 1, 2, 2, 2, 3, 3, 3, 4, 4, 5, 5, 5};
	localparam int brRs [15] = '{1, 1, 1, 1, 1, 3, 0, 3, 0, 1, 3, 1, 1, 0, 3};
	localparam int brRt [15] = '{2, 3, 3, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};

	logic        clk = 1'b0;
	logic        arstN;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWData;
	logic [3:0]  dmemByteEn;
	logic        dmemWrite;
	logic        dmemRead;
	logic [31:0] dmemRData;

	logic [31:0] imem [memWords];
	logic [31:0] dmem [memWords];
	logic [31:0] endAddr;
	int          progLen;
	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	int          readCount = 0;
	integer      seed = 32'hca3f;

	assign imemData  = imem[imemAddr[9:2]];
	assign dmemRData = dmem[dmemAddr[9:2]];

	mipsCore #(.resetPc(tbResetPc)) DUT (
		.clk       (clk),
		.arstN     (arstN),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.dmemAddr  (dmemAddr),
		.dmemWData (dmemWData),
		.dmemByteEn(dmemByteEn),
		.dmemWrite (dmemWrite),
		.dmemRead  (dmemRead),
		.dmemRData (dmemRData)
	);

	bind mipsCore mipsCoreAssert uAssert (
		.clk(clk), .arstN(arstN), .imemAddr(imemAddr), .dmemAddr(dmemAddr),
		.dmemByteEn(dmemByteEn), .dmemWrite(dmemWrite), .dmemRead(dmemRead)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("timeout: run exceeded %0d cycles", timeoutLimit);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// instruction encoders and program building
	//////////////////////////////////////////////////

	function automatic logic [31:0] addrOf(int idx);
		return tbResetPc + (32'(idx) << 2);
	endfunction

	function automatic logic [31:0] rType(functT fn, int rs, int rt, int rd, int sh);
		return {opRtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] iType(opcodeT op, int rs, int rt, logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] jType(opcodeT op, int idx);
		logic [31:0] target;
		target = addrOf(idx);
		return {op, target[27:2]};
	endfunction

	// taken branches skip one instruction
	function automatic logic [31:0] encodeBranch(int kind, int rs, int rt);
		case (kind)
			0: return iType(opBeq, rs, rt, 16'h0001);
			1: return iType(opBne, rs, rt, 16'h0001);
			2: return iType(opBgtz, rs, 0, 16'h0001);
			3: return iType(opBlez, rs, 0, 16'h0001);
			4: return iType(opRegimm, rs, 0, 16'h0001);
			default: return iType(opRegimm, rs, 1, 16'h0001);
		endcase
	endfunction

	function automatic bit branchRule(int kind, logic [31:0] x, logic [31:0] y);
		case (kind)
			0: return x == y;
			1: return x != y;
			2: return $signed(x) > 0;
			3: return $signed(x) <= 0;
			4: return $signed(x) < 0;
			default: return $signed(x) >= 0;
		endcase
	endfunction

	// odd multiplier keeps every word of the fill distinct
	function automatic logic [31:0] patternAt(int idx);
		return 32'h6b43_a9b5 ^ (32'(idx) * 32'h0100_0193);
	endfunction

	function automatic logic [31:0] mergeLanes(logic [31:0] old, logic [31:0] data,
			logic [3:0] lanes);
		logic [31:0] merged;
		merged = old;
		for (int i = 0; i < 4; i++) begin
			if (lanes[i]) merged[8*i +: 8] = data[8*i +: 8];
		end
		return merged;
	endfunction

	task automatic startProgram();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = '0;
			dmem[i] = patternAt(i);
		end
		progLen = 0;
		readCount = 0;
	endtask

	task automatic emit(logic [31:0] word);
		imem[progLen[7:0]] = word;
		progLen++;
	endtask

	task automatic emitHalt();
		endAddr = addrOf(progLen);
		emit(jType(opJ, progLen));
	endtask

	// ori, sll by 16, ori
	task automatic loadConst(int r, logic [31:0] value);
		emit(iType(opOri, 0, r, value[31:16]));
		emit(rType(fnSll, 0, r, r, 16));
		emit(iType(opOri, r, r, value[15:0]));
	endtask

	task automatic storeWord(int rt, int addr);
		emit(iType(opSw, 0, rt, 16'(addr)));
	endtask

	//////////////////////////////////////////////////
	// reset, clocking and checks
	//////////////////////////////////////////////////

	task automatic resetCore();
		@(posedge clk);
		#1 arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 arstN = 1'b1;
	endtask

	// store sampled mid-cycle, lands in memory just after the edge
	task automatic stepCycle();
		logic        wrEn;
		logic [31:0] wrAddr;
		logic [31:0] wrData;
		logic [3:0]  wrLanes;
		@(negedge clk);
		wrEn    = dmemWrite;
		wrAddr  = dmemAddr;
		wrData  = dmemWData;
		wrLanes = dmemByteEn;
		if (dmemRead) readCount++;
		@(posedge clk);
		#1;
		if (wrEn) dmem[wrAddr[9:2]] = mergeLanes(dmem[wrAddr[9:2]], wrData, wrLanes);
	endtask

	task automatic runUntilHalt(string what);
		int cycles;
		cycles = 0;
		while (imemAddr !== endAddr && cycles < cycleBudget) begin
			stepCycle();
			cycles++;
		end
		checkCount++;
		assert (imemAddr === endAddr) else begin
			errorCount++;
			$display("%s program did not reach its halt loop in %0d cycles", what, cycleBudget);
		end
	endtask

	task automatic checkWord(logic [31:0] addr, logic [31:0] expected, string what);
		logic [31:0] got;
		got = dmem[addr[9:2]];
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("error at %0t ns: dmem[0x%h] (%s) got 0x%h expected 0x%h",
				$time, addr, what, got, expected);
		end
	endtask

	// one read cycle per load instruction in the program
	task automatic checkReads(int expected, string what);
		checkCount++;
		assert (readCount == expected) else begin
			errorCount++;
			$display("error at %0t ns: dmemRead cycles (%s) got %0d expected %0d",
				$time, what, readCount, expected);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic testAluOps();
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  sh;
		a  = $random(seed);
		b  = $random(seed);
		sh = 5'($random(seed));
		startProgram();
		loadConst(1, a);
		loadConst(2, b);
		emit(rType(fnAdd, 1, 2, 3, 0));
		storeWord(3, 'h100);
		emit(rType(fnSub, 1, 2, 3, 0));
		storeWord(3, 'h104);
		emit(rType(fnAnd, 1, 2, 3, 0));
		storeWord(3, 'h108);
		emit(rType(fnOr, 1, 2, 3, 0));
		storeWord(3, 'h10c);
		emit(rType(fnNor, 1, 2, 3, 0));
		storeWord(3, 'h110);
		emit(rType(fnXor, 1, 2, 3, 0));
		storeWord(3, 'h114);
		emit(rType(fnSlt, 1, 2, 3, 0));
		storeWord(3, 'h118);
		emit(rType(fnSlt, 2, 1, 3, 0));
		storeWord(3, 'h11c);
		emit(rType(fnSll, 0, 2, 3, int'(sh)));
		storeWord(3, 'h120);
		emit(rType(fnSrl, 0, 2, 3, int'(sh)));
		storeWord(3, 'h124);
		emitHalt();
		resetCore();
		runUntilHalt("alu");
		checkWord(32'h100, a + b, "add");
		checkWord(32'h104, a - b, "sub");
		checkWord(32'h108, a & b, "and");
		checkWord(32'h10c, a | b, "or");
		checkWord(32'h110, ~(a | b), "nor");
		checkWord(32'h114, a ^ b, "xor");
		checkWord(32'h118, {31'b0, $signed(a) < $signed(b)}, "slt a b");
		checkWord(32'h11c, {31'b0, $signed(b) < $signed(a)}, "slt b a");
		checkWord(32'h120, b << sh, "sll");
		checkWord(32'h124, b >> sh, "srl");
		checkReads(0, "alu");
	endtask

	task automatic testImmediates();
		logic [31:0] a;
		logic [15:0] imm;
		logic [31:0] sext;
		logic [31:0] zext;
		a    = $random(seed);
		// negative immediate so the two extensions differ
		imm  = 16'($random(seed)) | 16'h8000;
		sext = {{16{imm[15]}}, imm};
		zext = {16'h0000, imm};
		startProgram();
		loadConst(1, a);
		emit(iType(opAddi, 1, 3, imm));
		storeWord(3, 'h140);
		emit(iType(opSlti, 1, 3, imm));
		storeWord(3, 'h144);
		emit(iType(opAndi, 1, 3, imm));
		storeWord(3, 'h148);
		emit(iType(opOri, 1, 3, imm));
		storeWord(3, 'h14c);
		emit(iType(opXori, 1, 3, imm));
		storeWord(3, 'h150);
		emitHalt();
		resetCore();
		runUntilHalt("immediate");
		checkWord(32'h140, a + sext, "addi");
		checkWord(32'h144, {31'b0, $signed(a) < $signed(sext)}, "slti");
		checkWord(32'h148, a & zext, "andi");
		checkWord(32'h14c, a | zext, "ori");
		checkWord(32'h150, a ^ zext, "xori");
		checkReads(0, "immediate");
	endtask

	task automatic testByteHalf();
		logic [31:0] v;
		logic [31:0] w;
		logic [7:0]  bt;
		logic [15:0] hw;
		v = $random(seed);
		// top byte and upper half negative
		w = $random(seed) | 32'h8080_0000;
		startProgram();
		dmem[8'(32'h220 >> 2)] = w;
		loadConst(1, v);
		for (int off = 0; off < 4; off++) begin
			emit(iType(opSb, 0, 1, 16'(32'h200 + 5 * off)));
		end
		emit(iType(opSh, 0, 1, 16'h0210));
		emit(iType(opSh, 0, 1, 16'h0216));
		for (int off = 0; off < 4; off++) begin
			emit(iType(opLb, 0, 3, 16'(32'h220 + off)));
			storeWord(3, 'h240 + 4 * off);
		end
		emit(iType(opLh, 0, 3, 16'h0220));
		storeWord(3, 'h250);
		emit(iType(opLh, 0, 3, 16'h0222));
		storeWord(3, 'h254);
		emit(iType(opLw, 0, 3, 16'h0220));
		storeWord(3, 'h258);
		emitHalt();
		resetCore();
		runUntilHalt("byte and half");
		for (int off = 0; off < 4; off++) begin
			checkWord(32'h200 + 32'(4 * off), mergeLanes(patternAt(128 + off), {4{v[7:0]}},
				4'(1 << off)), $sformatf("sb offset %0d", off));
			bt = 8'(w >> (8 * off));
			checkWord(32'h240 + 32'(4 * off), {{24{bt[7]}}, bt}, $sformatf("lb offset %0d", off));
		end
		checkWord(32'h210, mergeLanes(patternAt(132), {2{v[15:0]}}, 4'b0011), "sh offset 0");
		checkWord(32'h214, mergeLanes(patternAt(133), {2{v[15:0]}}, 4'b1100), "sh offset 2");
		hw = w[15:0];
		checkWord(32'h250, {{16{hw[15]}}, hw}, "lh offset 0");
		hw = w[31:16];
		checkWord(32'h254, {{16{hw[15]}}, hw}, "lh offset 2");
		checkWord(32'h258, w, "lw");
		// four lb, two lh and one lw
		checkReads(7, "byte and half loads");
	endtask

	task automatic testBranches();
		logic [31:0] regVal [4];
		logic [31:0] expected;
		regVal[0] = '0;
		regVal[1] = ($random(seed) & 32'h7fff_ffff) | 32'h1;
		regVal[2] = regVal[1];
		regVal[3] = $random(seed) | 32'h8000_0000;
		startProgram();
		for (int r = 1; r < 4; r++) loadConst(r, regVal[r]);
		// r5 keeps 0xaa if taken, 0x55 on fall-through
		for (int k = 0; k < 15; k++) begin
			emit(iType(opOri, 0, 5, 16'h00aa));
			emit(encodeBranch(brKind[k], brRs[k], brRt[k]));
			emit(iType(opOri, 0, 5, 16'h0055));
			storeWord(5, 'h280 + 4 * k);
		end
		emitHalt();
		resetCore();
		runUntilHalt("branch");
		for (int k = 0; k < 15; k++) begin
			expected = branchRule(brKind[k], regVal[brRs[k]], regVal[brRt[k]]) ? 32'haa : 32'h55;
			checkWord(32'h280 + 32'(4 * k), expected, $sformatf("branch case %0d", k));
		end
		checkReads(0, "branch");
	endtask

	task automatic testJumps();
		startProgram();
		emit(iType(opOri, 0, 5, 16'h0011));
		emit(jType(opJ, 3));
		emit(iType(opOri, 0, 5, 16'h0022));
		storeWord(5, 'h300);
		emit(jType(opJal, 8));
		storeWord(6, 'h308);
		emitHalt();
		emit(32'h0);
		// subroutine at index 8
		storeWord(31, 'h304);
		emit(iType(opOri, 0, 6, 16'h0033));
		emit(rType(fnJr, 31, 0, 0, 0));
		resetCore();
		runUntilHalt("jump");
		checkWord(32'h300, 32'h11, "j skip");
		checkWord(32'h304, addrOf(4) + 32'd4, "jal link");
		checkWord(32'h308, 32'h33, "jr return");
		checkReads(0, "jump");
	endtask

	task automatic testRegZero();
		logic [31:0] v;
		v = $random(seed);
		startProgram();
		loadConst(1, v);
		emit({6'b111111, 5'd0, 5'd1, 16'h1234});
		// unused store-like and load-like opcodes
		emit({6'b101111, 5'd0, 5'd1, 16'h038c});
		emit({6'b100111, 5'd0, 5'd1, 16'h0390});
		emit({opRtype, 5'd1, 5'd1, 5'd1, 5'd0, 6'b111111});
		// regimm with an unused rt must not branch
		emit({opRegimm, 5'd1, 5'd2, 16'h0001});
		storeWord(1, 'h388);
		emit(iType(opAddi, 1, 0, 16'h0005));
		emit(rType(fnAdd, 1, 1, 0, 0));
		storeWord(1, 'h380);
		storeWord(0, 'h384);
		emitHalt();
		resetCore();
		runUntilHalt("register zero");
		checkWord(32'h380, v, "r1 after unknown");
		checkWord(32'h384, 32'h0, "r0");
		checkWord(32'h388, v, "regimm no-op");
		checkWord(32'h38c, patternAt(227), "unknown store");
		checkWord(32'h390, patternAt(228), "untouched word");
		checkReads(0, "unknown load");
	endtask

	initial begin
		arstN = 1'b0;
		testAluOps();
		testImmediates();
		testByteHalf();
		testBranches();
		testJumps();
		testRegZero();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb/mipsCore_assert.sv */
`timescale 1ns/100ps

module mipsCoreAssert (
	input logic        clk,
	input logic        arstN,
	input logic [31:0] imemAddr,
	input logic [31:0] dmemAddr,
	input logic [3:0]  dmemByteEn,
	input logic        dmemWrite,
	input logic        dmemRead
);

	// a load and a store never share a cycle
	noReadWrite: assert property (@(posedge clk) !(dmemRead && dmemWrite))
		else $error("dmemRead and dmemWrite high in the same cycle");

	wordAligned: assert property (@(posedge clk) disable iff (!arstN)
		(imemAddr[1:0] == 2'b00) && (dmemAddr[1:0] == 2'b00))
		else $error("memory address not word aligned");

	// lanes only mean something on a store
	idleLanes: assert property (@(posedge clk) !dmemWrite |-> (dmemByteEn == 4'b0000))
		else $error("dmemByteEn active without dmemWrite");

	quietInReset: assert property (@(posedge clk)
		!arstN |-> (!dmemWrite && !dmemRead && (dmemByteEn == 4'b0000)))
		else $error("memory strobe active during reset");

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore #(
	parameter logic [mipsPkg::dataWidth-1:0] resetPc = '0
) (
	input  logic                          clk,
	input  logic                          arstN,
	output logic [mipsPkg::dataWidth-1:0] imemAddr,
	input  logic [mipsPkg::dataWidth-1:0] imemData,
	output logic [mipsPkg::dataWidth-1:0] dmemAddr,
	output logic [mipsPkg::dataWidth-1:0] dmemWData,
	output logic [3:0]                    dmemByteEn,
	output logic                          dmemWrite,
	output logic                          dmemRead,
	input  logic [mipsPkg::dataWidth-1:0] dmemRData
);
	import mipsPkg::*;

	ctrlBus ctrl ();

	logic [dataWidth-1:0]    pc;
	logic [dataWidth-1:0]    pcPlus4;
	logic [dataWidth-1:0]    pcNext;
	logic [dataWidth-1:0]    branchTarget;
	logic [dataWidth-1:0]    jumpTarget;
	logic [dataWidth-1:0]    rsData;
	logic [dataWidth-1:0]    rtData;
	logic [dataWidth-1:0]    immExt;
	logic [dataWidth-1:0]    aluA;
	logic [dataWidth-1:0]    aluB;
	logic [dataWidth-1:0]    aluResult;
	logic [dataWidth-1:0]    loadData;
	logic [dataWidth-1:0]    wrData;
	logic [regAddrWidth-1:0] wrAddr;
	logic                    wrEn;
	logic                    branchTaken;
	logic [1:0]              byteOffset;
	logic [7:0]              loadByte;
	logic [15:0]             loadHalf;
	logic [3:0]              byteEn;

	control uControl (
		.instr(imemData),
		.ctrl (ctrl)
	);

	regFile uRegFile (
		.clk   (clk),
		.arstN (arstN),
		.rs    (imemData[25:21]),
		.rt    (imemData[20:16]),
		.rsData(rsData),
		.rtData(rtData),
		.wrEn  (wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	alu uAlu (
		.a          (aluA),
		.b          (aluB),
		.shamt      (aluA[4:0]),
		.ctrl       (ctrl),
		.result     (aluResult),
		.branchTaken(branchTaken)
	);

	//////////////////////////////////////////////////
	// program counter
	//////////////////////////////////////////////////

	assign imemAddr     = pc;
	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + {{14{imemData[15]}}, imemData[15:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], imemData[25:0], 2'b00};

	always_comb begin
		case (ctrl.pcSel)
			pcBranch: pcNext = branchTaken ? branchTarget : pcPlus4;
			pcJump:   pcNext = jumpTarget;
			pcReg:    pcNext = rsData;
			default:  pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
		end else begin
			pc <= pcNext;
		end
	end

	// operand selection
	assign immExt = ctrl.zeroExt ? {16'b0, imemData[15:0]} : {{16{imemData[15]}}, imemData[15:0]};
	assign aluA   = ctrl.shiftA ? {27'b0, imemData[10:6]} : rsData;
	assign aluB   = ctrl.aluSrcImm ? immExt : rtData;

	//////////////////////////////////////////////////
	// data memory, little-endian lanes
	//////////////////////////////////////////////////

	assign dmemAddr   = {aluResult[dataWidth-1:2], 2'b00};
	assign byteOffset = aluResult[1:0];

	always_comb begin
		case (ctrl.memSize)
			sizeByte: begin
				dmemWData = {4{rtData[7:0]}};
				byteEn    = 4'b0001 << byteOffset;
			end
			sizeHalf: begin
				dmemWData = {2{rtData[15:0]}};
				byteEn    = byteOffset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dmemWData = rtData;
				byteEn    = 4'b1111;
			end
		endcase
	end

	// no strobes while the core is held in reset
	assign dmemWrite  = ctrl.memWrite & arstN;
	assign dmemRead   = ctrl.memRead & arstN;
	assign dmemByteEn = dmemWrite ? byteEn : 4'b0000;

	assign loadByte = dmemRData[{byteOffset, 3'b000} +: 8];
	assign loadHalf = dmemRData[{byteOffset[1], 4'b0000} +: 16];

	always_comb begin
		case (ctrl.memSize)
			sizeByte: loadData = {{24{loadByte[7]}}, loadByte};
			sizeHalf: loadData = {{16{loadHalf[15]}}, loadHalf};
			default:  loadData = dmemRData;
		endcase
	end

	// write back
	always_comb begin
		case (ctrl.dest)
			destRt:  wrAddr = imemData[20:16];
			destRd:  wrAddr = imemData[15:11];
			destRa:  wrAddr = 5'd31;
			default: wrAddr = '0;
		endcase
	end

	assign wrEn   = (ctrl.dest != destNone);
	assign wrData = ctrl.memToReg ? loadData : (ctrl.dest == destRa) ? pcPlus4 : aluResult;

endmodule

/* logic/regFile.sv */
`timescale 1ns/100ps

module regFile (
	input  logic                                 clk,
	input  logic                                 arstN,
	input  logic [mipsPkg::regAddrWidth-1:0]    rs,
	input  logic [mipsPkg::regAddrWidth-1:0]    rt,
	output logic [mipsPkg::dataWidth-1:0]       rsData,
	output logic [mipsPkg::dataWidth-1:0]       rtData,
	input  logic                                 wrEn,
	input  logic [mipsPkg::regAddrWidth-1:0]    wrAddr,
	input  logic [mipsPkg::dataWidth-1:0]       wrData
);
	import mipsPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];

	// r0 is never written so it stays at its reset value of zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// combinational reads, same-cycle write not forwarded
	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule

/* logic/alu.sv */
`timescale 1ns/100ps

module alu (
	input  logic [mipsPkg::dataWidth-1:0] a,
	input  logic [mipsPkg::dataWidth-1:0] b,
	input  logic [4:0]                    shamt,
	ctrlBus.datapath                      ctrl,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic                          branchTaken
);
	import mipsPkg::*;

	logic signed [dataWidth-1:0] aSigned;
	logic signed [dataWidth-1:0] bSigned;
	logic                        lessThan;

	assign aSigned  = a;
	assign bSigned  = b;
	assign lessThan = aSigned < bSigned;

	//////////////////////////////////////////////////
	// result
	//////////////////////////////////////////////////

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   result = a + b;
			aluSub:   result = a - b;
			aluAnd:   result = a & b;
			aluOr:    result = a | b;
			aluNor:   result = ~(a | b);
			aluXor:   result = a ^ b;
			// shifts move the B operand (rt)
			aluSll:   result = b << shamt;
			aluSrl:   result = b >> shamt;
			aluSlt:   result = {{(dataWidth - 1){1'b0}}, lessThan};
			aluPassA: result = a;
			default:  result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// branch condition
	//////////////////////////////////////////////////

	always_comb begin
		case (ctrl.branchCond)
			brEq:    branchTaken = (a == b);
			brNe:    branchTaken = (a != b);
			// the rest test rs against zero
			brGtz:   branchTaken = (aSigned > 0);
			brLez:   branchTaken = (aSigned <= 0);
			brLtz:   branchTaken = a[dataWidth-1];
			brGez:   branchTaken = ~a[dataWidth-1];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

/* logic/control.sv */
`timescale 1ns/100ps

module control (
	input  logic [mipsPkg::dataWidth-1:0] instr,
	ctrlBus.decoder                       ctrl
);
	import mipsPkg::*;

	opcodeT                  opcode;
	functT                   funct;
	logic [regAddrWidth-1:0] rtField;
	memSizeT                 accessSize;

	assign opcode  = opcodeT'(instr[31:26]);
	assign funct   = functT'(instr[5:0]);
	assign rtField = instr[20:16];

	// low two opcode bits give the access width of loads and stores
	assign accessSize = (instr[27:26] == 2'b00) ? sizeByte :
	                    (instr[27:26] == 2'b01) ? sizeHalf : sizeWord;

	always_comb begin
		// no-op pattern unless recognised below
		ctrl.aluOp      = aluAdd;
		ctrl.aluSrcImm  = 1'b0;
		ctrl.shiftA     = 1'b0;
		ctrl.zeroExt    = 1'b0;
		ctrl.dest       = destNone;
		ctrl.memToReg   = 1'b0;
		ctrl.memRead    = 1'b0;
		ctrl.memWrite   = 1'b0;
		ctrl.memSize    = sizeWord;
		ctrl.pcSel      = pcSeq;
		ctrl.branchCond = brNever;

		case (opcode)
			//////////////////////////////////////////////////
			// register forms
			//////////////////////////////////////////////////
			opRtype: begin
				ctrl.dest = destRd;
				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr:  ctrl.aluOp = aluOr;
					fnNor: ctrl.aluOp = aluNor;
					fnXor: ctrl.aluOp = aluXor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSll: begin
						ctrl.aluOp  = aluSll;
						ctrl.shiftA = 1'b1;
					end
					fnSrl: begin
						ctrl.aluOp  = aluSrl;
						ctrl.shiftA = 1'b1;
					end
					fnJr: begin
						ctrl.aluOp = aluPassA;
						ctrl.dest  = destNone;
						ctrl.pcSel = pcReg;
					end
					default: ctrl.dest = destNone;
				endcase
			end

			//////////////////////////////////////////////////
			// immediate forms
			//////////////////////////////////////////////////
			opAddi, opSlti, opAndi, opOri, opXori: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.dest      = destRt;
				// logical immediates are zero-extended
				ctrl.zeroExt   = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
				case (opcode)
					opSlti:  ctrl.aluOp = aluSlt;
					opAndi:  ctrl.aluOp = aluAnd;
					opOri:   ctrl.aluOp = aluOr;
					opXori:  ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluAdd;
				endcase
			end

			// base plus offset
			opLb, opLh, opLw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.dest      = destRt;
				ctrl.memToReg  = 1'b1;
				ctrl.memRead   = 1'b1;
				ctrl.memSize   = accessSize;
			end
			opSb, opSh, opSw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite  = 1'b1;
				ctrl.memSize   = accessSize;
			end

			//////////////////////////////////////////////////
			// branches and jumps
			//////////////////////////////////////////////////
			opBeq: begin
				ctrl.pcSel      = pcBranch;
				ctrl.branchCond = brEq;
			end
			opBne: begin
				ctrl.pcSel      = pcBranch;
				ctrl.branchCond = brNe;
			end
			opBgtz: begin
				ctrl.pcSel      = pcBranch;
				ctrl.branchCond = brGtz;
			end
			opBlez: begin
				ctrl.pcSel      = pcBranch;
				ctrl.branchCond = brLez;
			end
			// bltz and bgez share an opcode, rt picks
			opRegimm: begin
				if (rtField == 5'd0) begin
					ctrl.pcSel      = pcBranch;
					ctrl.branchCond = brLtz;
				end else if (rtField == 5'd1) begin
					ctrl.pcSel      = pcBranch;
					ctrl.branchCond = brGez;
				end
			end
			opJ: ctrl.pcSel = pcJump;
			opJal: begin
				ctrl.pcSel = pcJump;
				ctrl.dest  = destRa;
			end
			default: ctrl.pcSel = pcSeq;
		endcase
	end

endmodule

/* logic/ctrlBus.sv */
`timescale 1ns/100ps

interface ctrlBus;
	import mipsPkg::*;

	aluOpT      aluOp;
	logic       aluSrcImm;
	logic       shiftA;
	logic       zeroExt;
	destSelT    dest;
	logic       memToReg;
	logic       memRead;
	logic       memWrite;
	memSizeT    memSize;
	pcSelT      pcSel;
	branchCondT branchCond;

	// decoder side drives everything
	modport decoder (
		output aluOp, aluSrcImm, shiftA, zeroExt, dest, memToReg,
		output memRead, memWrite, memSize, pcSel, branchCond
	);

	// datapath and alu only look
	modport datapath (
		input aluOp, aluSrcImm, shiftA, zeroExt, dest, memToReg,
		input memRead, memWrite, memSize, pcSel, branchCond
	);

endinterface

/* logic/mipsPkg.sv */
package mipsPkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		opRtype  = 6'b000000,
		opRegimm = 6'b000001,
		opJ      = 6'b000010,
		opJal    = 6'b000011,
		opBeq    = 6'b000100,
		opBne    = 6'b000101,
		opBlez   = 6'b000110,
		opBgtz   = 6'b000111,
		opAddi   = 6'b001000,
		opSlti   = 6'b001010,
		opAndi   = 6'b001100,
		opOri    = 6'b001101,
		opXori   = 6'b001110,
		opLb     = 6'b100000,
		opLh     = 6'b100001,
		opLw     = 6'b100011,
		opSb     = 6'b101000,
		opSh     = 6'b101001,
		opSw     = 6'b101011
	} opcodeT;

	// function field of R-type words
	typedef enum logic [5:0] {
		fnSll = 6'b000000,
		fnSrl = 6'b000010,
		fnJr  = 6'b001000,
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnXor = 6'b100110,
		fnNor = 6'b100111,
		fnSlt = 6'b101010
	} functT;

	//////////////////////////////////////////////////
	// decoded control fields
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor, aluSll, aluSrl, aluSlt, aluPassA
	} aluOpT;

	typedef enum logic [2:0] {brNever, brEq, brNe, brGtz, brLez, brLtz, brGez} branchCondT;

	typedef enum logic [1:0] {destNone, destRt, destRd, destRa} destSelT;

	typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} memSizeT;

	typedef enum logic [1:0] {pcSeq, pcBranch, pcJump, pcReg} pcSelT;

endpackage
